// ==== verilog.f ====
+incdir+rtl
rtl/knight_pkg.sv
rtl/tour_logic.sv
rtl/tour_replay.sv
rtl/tour_wb_regs.sv
rtl/knight_tour_top.sv
tb/tb_knight_tour.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the knight's tour testbench with Verilator and runs it.
# A failing check ends the simulation with a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f verilog.f \
  --top-module tb_knight_tour \
  -o tb_knight_tour

./obj_dir/tb_knight_tour

echo "Simulation finished"

// ==== tb/tb_knight_tour.sv ====
`include "knight_defines.svh"

module tb_knight_tour
  import knight_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_TOURS         = 8;          // Six chosen squares, one busy test, one retry.
  localparam int CYCLES_PER_TOUR = 1_000_000;  // Budget for one search and its polling.

  // Knight offsets per one-hot bit, bit 0 first.
  localparam int DX_TAB [8] = '{1, -1, -2, -2, -1, 1, 2, 2};
  localparam int DY_TAB [8] = '{2, 2, 1, -1, -2, -2, -1, 1};

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [31:0] lcg_state = 32'h009f5124;   // Start square generator state.

  knight_tour_top uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period.
  end

  //////////////////////////////////////////////////
  // Error exits.
  //////////////////////////////////////////////////
  task automatic value_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    $display("Something failed");
    $display("Fail %s expected 0x%h actual 0x%h", name, exp, act);
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("Something failed");
    $display("%s", why);
    $fatal(1);
  endtask

  // The slave answers every sampled request one cycle later, for one cycle only.
  ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else abort_run("ack stayed high for more than one cycle");
  ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
    else abort_run("ack did not follow a sampled request");
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else abort_run("ack appeared without a request");

  //////////////////////////////////////////////////
  // Bus access and stimulus helpers.
  //////////////////////////////////////////////////
  // Called 1 ns after a rising edge; returns 1 ns after the ack edge.
  task automatic bus_access(input logic we, input int adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int waited;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = `KT_ADR_W'(adr);
    wb_req.dat = wdat;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;          // Edges seen since the request went up.
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    @(posedge clk);      // The request stays up through the ack cycle.
    #1;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    assert (waited == 1) else value_mismatch("ack latency", 32'd1, 32'(waited));
  endtask

  task automatic write_reg(input int adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic read_reg(input int adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'd0, data);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Draws squares until one has an even coordinate sum.
  task automatic pick_square(output int x, output int y);
    do begin
      lcg_state = lcg_next(lcg_state);
      x = int'(lcg_state[23:16]) % `KT_DIM;
      y = int'(lcg_state[31:24]) % `KT_DIM;
    end while (((x + y) % 2) != 0);
  endtask

  function automatic logic [31:0] ctrl_word(input int x, input int y);
    return {1'b1, 25'd0, 3'(y), 3'(x)};   // Start bit, then y above x.
  endfunction

  function automatic int move_index(input move_t m);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) return b;
    end
    return 0;
  endfunction

  //////////////////////////////////////////////////
  // Tour checks.
  //////////////////////////////////////////////////
  task automatic wait_tour_done();
    logic [31:0] st;
    read_reg(`KT_REG_STAT, st);
    while (!st[1]) begin
      assert (st == 32'h1) else value_mismatch("STAT while searching", 32'h1, st);
      read_reg(`KT_REG_STAT, st);
    end
    assert (st == 32'h2) else value_mismatch("STAT after tour", 32'h2, st);
  endtask

  // Replays the trace from the start square and marks every square reached.
  task automatic check_tour(input int sx, input int sy);
    logic [31:0]  rd;
    trace_entry_t te;
    bit           seen [25];
    int           px;
    int           py;
    int           nx;
    int           ny;
    int           k;
    foreach (seen[s]) seen[s] = 1'b0;
    seen[sy * `KT_DIM + sx] = 1'b1;
    px = sx;
    py = sy;
    for (int i = 0; i < `KT_MOVES; i++) begin
      read_reg(`KT_TRACE_BASE + i, rd);
      te = rd[13:0];
      assert (rd[31:14] == 18'd0)
        else value_mismatch("TRACE upper bits", 32'd0, 32'(rd[31:14]));
      assert ($onehot(te.move))
        else abort_run($sformatf("Trace entry %0d move %h is not one-hot", i, te.move));
      assert (te.dest.x < `KT_DIM && te.dest.y < `KT_DIM)
        else abort_run($sformatf("Trace entry %0d lands off the board", i));
      k  = move_index(te.move);
      nx = px + DX_TAB[k];
      ny = py + DY_TAB[k];
      assert (32'(te.dest.x) == 32'(nx))
        else value_mismatch("trace dest.x", 32'(nx), 32'(te.dest.x));
      assert (32'(te.dest.y) == 32'(ny))
        else value_mismatch("trace dest.y", 32'(ny), 32'(te.dest.y));
      assert (!seen[ny * `KT_DIM + nx])
        else abort_run($sformatf("Trace entry %0d revisits square (%0d,%0d)", i, nx, ny));
      seen[ny * `KT_DIM + nx] = 1'b1;
      px = nx;
      py = ny;
    end
  endtask

  task automatic expect_stat(input string name, input logic [31:0] exp);
    logic [31:0] st;
    read_reg(`KT_REG_STAT, st);
    assert (st == exp) else value_mismatch(name, exp, st);
  endtask

  task automatic run_tour(input int x, input int y);
    write_reg(`KT_REG_CTRL, ctrl_word(x, y));
    expect_stat("STAT after start", 32'h1);   // Busy, with ready and rejected cleared.
    wait_tour_done();
    check_tour(x, y);
  endtask

  // Ends a run that hangs, with a budget per tour.
  initial begin
    repeat (N_TOURS * CYCLES_PER_TOUR) @(posedge clk);
    abort_run("Timeout: the tours did not finish in the allowed number of cycles");
  end

  //////////////////////////////////////////////////
  // Main sequence.
  //////////////////////////////////////////////////
  initial begin
    int x;
    int y;
    rst_n  = 1'b0;
    wb_req = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    assert (wb_rsp.ack == 1'b0) else value_mismatch("wb_rsp.ack", 32'd0, 32'(wb_rsp.ack));
    expect_stat("STAT after reset", 32'h0);

    // Off-board and odd squares are refused and start nothing.
    write_reg(`KT_REG_CTRL, ctrl_word(5, 1));
    expect_stat("STAT after x off board", 32'h4);
    write_reg(`KT_REG_CTRL, ctrl_word(0, 6));
    expect_stat("STAT after y off board", 32'h4);
    write_reg(`KT_REG_CTRL, ctrl_word(1, 2));
    expect_stat("STAT after odd square", 32'h4);
    repeat (50) @(posedge clk);
    #1;
    expect_stat("STAT idle after reject", 32'h4);

    // Six tours. The first also clears the earlier rejection.
    run_tour(0, 0);
    run_tour(2, 2);
    for (int t = 0; t < 4; t++) begin
      pick_square(x, y);
      run_tour(x, y);
    end

    // Starts while busy are dropped, good or bad.
    write_reg(`KT_REG_CTRL, ctrl_word(4, 4));
    write_reg(`KT_REG_CTRL, ctrl_word(2, 2));
    expect_stat("STAT after start while busy", 32'h1);
    write_reg(`KT_REG_CTRL, ctrl_word(1, 0));
    expect_stat("STAT after bad start while busy", 32'h1);
    wait_tour_done();
    check_tour(4, 4);

    // A refusal clears ready, then a good start clears the refusal.
    write_reg(`KT_REG_CTRL, ctrl_word(3, 4));
    expect_stat("STAT after reject of ready tour", 32'h4);
    run_tour(1, 3);

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== rtl/knight_tour_top.sv ====
module knight_tour_top
  import knight_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req,    // Host Wishbone request.
  output wb_rsp_t wb_rsp     // Ack and read data back to the host.
);

  logic         go;           // Accepted start pulse.
  pos_t         start;        // Accepted start square.
  logic         done;         // Solver finished.
  move_t        move;         // Solver move at indx.
  logic [4:0]   indx;         // Replay read pointer into the solver.
  logic         trace_ready;  // Replay holds a complete trace.
  logic [4:0]   rd_idx;       // Host trace read index.
  trace_entry_t trace_entry;  // Trace entry at rd_idx.

  //////////////////////////////////////////////////
  // Host registers, solver and replay.
  //////////////////////////////////////////////////
  tour_wb_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .go          (go),
    .start       (start),
    .trace_ready (trace_ready),
    .rd_idx      (rd_idx),
    .trace_entry (trace_entry)
  );

  tour_logic u_logic (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (go),
    .start (start),
    .indx  (indx),
    .done  (done),
    .move  (move)
  );

  // Turns the stored move list into squares once the solver is done.
  tour_replay u_replay (
    .clk         (clk),
    .rst_n       (rst_n),
    .go          (go),
    .done        (done),
    .start       (start),
    .move        (move),
    .indx        (indx),
    .rd_idx      (rd_idx),
    .trace_entry (trace_entry),
    .trace_ready (trace_ready)
  );

endmodule

// ==== rtl/tour_wb_regs.sv ====
`include "knight_defines.svh"

module tour_wb_regs
  import knight_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  wb_req_t      wb_req,
  output wb_rsp_t      wb_rsp,
  output logic         go,           // One-cycle start pulse to the solver and replay.
  output pos_t         start,        // Accepted start square.
  input  logic         trace_ready,  // Replay has stored the full trace.
  output logic [4:0]   rd_idx,       // Trace entry picked by the address offset.
  input  trace_entry_t trace_entry
);

  logic        ack_q;         // Single-cycle Wishbone ack.
  logic [31:0] rdat_q;        // Read data returned with ack.
  logic        busy_q;        // A search is running.
  logic        ready_q;       // A stored tour is readable.
  logic        rejected_q;    // The last start request was refused.
  logic        trace_ready_q; // Previous trace_ready, for edge detection.
  logic        trace_rise;    // Replay finished this cycle.
  logic        busy;          // Busy as seen by the host.
  logic        ready;         // Ready as seen by the host.
  logic        access;        // A new request is sampled this cycle.
  logic        start_req;     // CTRL write with the start bit set.
  logic        req_ok;        // Start square is on the board and even.
  logic        in_trace;      // Address falls in the trace window.
  logic [31:0] stat_word;
  pos_t        req_pos;

  //////////////////////////////////////////////////
  // Bus decode.
  //////////////////////////////////////////////////
  assign access    = wb_req.cyc & wb_req.stb & ~ack_q;  // No second ack on a held request.
  assign start_req = access & wb_req.we & wb_req.dat[31]
                   & (wb_req.adr == `KT_ADR_W'(`KT_REG_CTRL));
  assign in_trace  = (wb_req.adr >= `KT_ADR_W'(`KT_TRACE_BASE))
                   && (wb_req.adr < `KT_ADR_W'(`KT_TRACE_BASE + `KT_MOVES));
  assign rd_idx    = 5'(wb_req.adr - `KT_ADR_W'(`KT_TRACE_BASE));

  // Open tours on 5x5 exist only from squares with an even coordinate sum.
  assign req_pos = wb_req.dat[5:0];
  assign req_ok  = (req_pos.x < 3'(`KT_DIM)) && (req_pos.y < 3'(`KT_DIM))
                && (req_pos.x[0] == req_pos.y[0]);

  // Busy drops and ready rises in the very cycle the replay finishes.
  assign trace_rise = trace_ready & ~trace_ready_q;
  assign busy       = busy_q & ~trace_rise;
  assign ready      = ready_q | trace_rise;
  assign stat_word  = {29'd0, rejected_q, ready, busy};

  //////////////////////////////////////////////////
  // Control and status flags.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ack_q         <= 1'b0;
      go            <= 1'b0;
      busy_q        <= 1'b0;
      ready_q       <= 1'b0;
      rejected_q    <= 1'b0;
      trace_ready_q <= 1'b0;
    end else begin
      ack_q         <= access;
      trace_ready_q <= trace_ready;
      go            <= 1'b0;
      if (trace_rise) begin
        busy_q  <= 1'b0;
        ready_q <= 1'b1;
      end
      // A request while busy leaves every flag alone.
      if (start_req && !busy) begin
        ready_q <= 1'b0;
        if (req_ok) begin
          busy_q     <= 1'b1;
          rejected_q <= 1'b0;
          go         <= 1'b1;     // Lines up with the ack cycle.
        end else begin
          rejected_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_req && !busy && req_ok)
      start <= req_pos;           // Held stable for the whole search.
  end

  // Read data is captured with the request and presented alongside ack.
  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_req.we)
        rdat_q <= '0;
      else if (wb_req.adr == `KT_ADR_W'(`KT_REG_STAT))
        rdat_q <= stat_word;
      else if (in_trace)
        rdat_q <= 32'(trace_entry);
      else
        rdat_q <= '0;             // CTRL and unmapped words read as zero.
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat_q;

endmodule

// ==== rtl/tour_replay.sv ====
`include "knight_defines.svh"

module tour_replay
  import knight_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         go,           // New search. Drops the old trace.
  input  logic         done,         // Solver finished. Replay starts next cycle.
  input  pos_t         start,        // Start square of the search.
  input  move_t        move,         // Solver move at indx.
  output logic [4:0]   indx,         // Depth being replayed.
  input  logic [4:0]   rd_idx,       // Trace entry asked for by the register block.
  output trace_entry_t trace_entry,  // Entry at rd_idx, zero past the end.
  output logic         trace_ready   // The whole trace is stored.
);

  trace_entry_t trace [`KT_MOVES];   // One entry per move of the tour.
  trace_entry_t step;                // Entry built from the current move.
  pos_t         pos_q;               // Square the knight stands on during replay.
  logic         active;              // Replay walk in progress.
  logic         last_step;           // Walk reaches the final move this cycle.

  assign last_step = (indx == 5'(`KT_MOVES - 1));

  // Each step is the running square plus the decoded move offset.
  assign step.move   = move;
  assign step.dest.x = pos_q.x + move_dx(move);
  assign step.dest.y = pos_q.y + move_dy(move);

  //////////////////////////////////////////////////
  // Walk control.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      active      <= 1'b0;
      indx        <= 5'd0;
      trace_ready <= 1'b0;
    end else if (go) begin
      active      <= 1'b0;
      indx        <= 5'd0;
      trace_ready <= 1'b0;       // The old trace is no longer valid.
    end else if (done) begin
      active <= 1'b1;            // Index 0 is read on the next cycle.
      indx   <= 5'd0;
    end else if (active) begin
      if (last_step) begin
        active      <= 1'b0;
        trace_ready <= 1'b1;     // All 24 entries are written at this edge.
      end else begin
        indx <= indx + 5'd1;
      end
    end
  end

  // The running square starts at the captured start square and follows the walk.
  always_ff @(posedge clk) begin
    if (go)
      pos_q <= start;
    else if (active)
      pos_q <= step.dest;
  end

  always_ff @(posedge clk) begin
    if (active)
      trace[indx] <= step;
  end

  //////////////////////////////////////////////////
  // Read port.
  //////////////////////////////////////////////////
  // Indices past the tour read as zero.
  assign trace_entry = (rd_idx < 5'(`KT_MOVES)) ? trace[rd_idx] : '0;

endmodule

// ==== rtl/tour_logic.sv ====
`include "knight_defines.svh"

module tour_logic
  import knight_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,      // Starts a new search from start.
  input  pos_t       start,   // Start square, already checked by the register block.
  input  logic [4:0] indx,    // Selects which stored move appears on move.
  output logic       done,    // One-cycle pulse when the 24th move lands.
  output move_t      move     // Stored move at depth indx.
);

  typedef enum logic [2:0] {IDLE, INIT, POSSIBLE, MAKE_MOVE, BACKUP} state_t;

  //////////////////////////////////////////////////
  // Search state.
  //////////////////////////////////////////////////
  logic [4:0] board [64];               // Move number per square, zero when unvisited.
  move_t      last_move [`KT_MOVES];    // Move taken (or being retried) at each depth.
  move_t      poss_moves [`KT_MOVES];   // In-bounds moves from the square at each depth.
  move_t      move_try;                 // Candidate move at the current depth.
  logic [4:0] move_num;                 // Current depth in the tour.
  logic [4:0] prev_num;                 // Depth we return to on a backup.
  pos_t       cur;                      // Square the knight stands on.
  pos_t       nxt_pos;                  // Square that move_try would reach.
  pos_t       back_pos;                 // Square the knight came from.

  // Control strobes from the FSM.
  logic       zero;                     // Clear the board and depth counter.
  logic       init;                     // Place the knight on the start square.
  logic       calc;                     // Capture the in-bounds mask for this square.
  logic       update_position;          // Commit move_try and step forward.
  logic       next_move;                // Shift to the next candidate.
  logic       backup;                   // Undo the last committed move.
  logic       move_poss;                // Candidate is on the board and unvisited.
  logic       have_move;                // Candidates remain at this depth.
  logic       prev_have_move;           // Candidates remain at the depth we backed into.
  logic       tour_done;                // Current depth is the last move of the tour.
  state_t     state, nxt_state;

  // The legal moves from a square are the intersection of an x mask and a y mask.
  function automatic move_t calc_poss(pos_t p);
    move_t xm;
    move_t ym;
    case (p.x)
      3'd0:    xm = 8'b1110_0001;   // Only moves with dx >= 0.
      3'd1:    xm = 8'b1111_0011;   // No dx of -2.
      3'd2:    xm = 8'b1111_1111;
      3'd3:    xm = 8'b0011_1111;   // No dx of +2.
      3'd4:    xm = 8'b0001_1110;   // Only moves with dx <= 0.
      default: xm = 8'b0000_0000;
    endcase
    case (p.y)
      3'd0:    ym = 8'b1000_0111;
      3'd1:    ym = 8'b1100_1111;
      3'd2:    ym = 8'b1111_1111;
      3'd3:    ym = 8'b1111_1100;
      3'd4:    ym = 8'b0111_1000;
      default: ym = 8'b0000_0000;
    endcase
    return xm & ym;
  endfunction

  assign prev_num = move_num - 5'd1;

  // Forward and reverse steps from the current square.
  assign nxt_pos.x  = cur.x + move_dx(move_try);
  assign nxt_pos.y  = cur.y + move_dy(move_try);
  assign back_pos.x = cur.x - move_dx(last_move[prev_num]);
  assign back_pos.y = cur.y - move_dy(last_move[prev_num]);

  // The mask check also guarantees nxt_pos is a real square before the board is trusted.
  assign move_poss = (|(poss_moves[move_num] & move_try)) && (board[nxt_pos] == 5'd0);
  assign have_move      = (move_try != 8'h80);           // Bit 7 is the last one tried.
  assign prev_have_move = (last_move[move_num] != 8'h80);
  assign tour_done      = (move_num == 5'(`KT_MOVES - 1));

  assign move = last_move[indx];   // Read port for the replay unit.

  //////////////////////////////////////////////////
  // Datapath registers.
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (zero) begin
      for (int i = 0; i < 64; i++) begin
        board[i] <= 5'd0;
      end
    end else if (init) begin
      board[start] <= 5'd1;                  // The start square is move number 1.
    end else if (update_position) begin
      board[nxt_pos] <= move_num + 5'd2;
    end else if (backup) begin
      board[cur] <= 5'd0;                    // Free the square we are leaving.
    end
  end

  always_ff @(posedge clk) begin
    if (init)
      cur <= start;
    else if (update_position)
      cur <= nxt_pos;
    else if (backup)
      cur <= back_pos;
  end

  always_ff @(posedge clk) begin
    if (zero)
      move_num <= 5'd0;
    else if (update_position)
      move_num <= move_num + 5'd1;
    else if (backup)
      move_num <= prev_num;
  end

  // Candidates start at bit 0. A backup resumes just past the move that failed.
  always_ff @(posedge clk) begin
    if (calc)
      move_try <= 8'h01;
    else if (next_move)
      move_try <= {move_try[6:0], 1'b0};
    else if (backup)
      move_try <= {last_move[prev_num][6:0], 1'b0};
  end

  always_ff @(posedge clk) begin
    if (calc)
      poss_moves[move_num] <= calc_poss(cur);
  end

  always_ff @(posedge clk) begin
    if (update_position)
      last_move[move_num] <= move_try;   // Becomes the stored solution at the end.
  end

  //////////////////////////////////////////////////
  // Control FSM.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state       = state;
    zero            = 1'b0;
    init            = 1'b0;
    calc            = 1'b0;
    update_position = 1'b0;
    next_move       = 1'b0;
    backup          = 1'b0;
    done            = 1'b0;

    case (state)
      INIT: begin
        init      = 1'b1;
        nxt_state = POSSIBLE;
      end
      POSSIBLE: begin
        calc      = 1'b1;          // Mask for the new square, first candidate.
        nxt_state = MAKE_MOVE;
      end
      MAKE_MOVE: begin
        if (move_poss) begin
          update_position = 1'b1;
          if (tour_done) begin
            done      = 1'b1;      // Last move lands this cycle.
            nxt_state = IDLE;
          end else begin
            nxt_state = POSSIBLE;
          end
        end else if (have_move) begin
          next_move = 1'b1;
        end else begin
          backup    = 1'b1;        // Dead end, so step back one square.
          nxt_state = BACKUP;
        end
      end
      BACKUP: begin
        // Keep unwinding while the depth we land on has also run out of moves.
        if (prev_have_move)
          nxt_state = MAKE_MOVE;
        else
          backup = 1'b1;
      end
      default: begin               // IDLE waits for a start.
        if (go) begin
          zero      = 1'b1;
          nxt_state = INIT;
        end
      end
    endcase
  end

endmodule

// ==== rtl/knight_pkg.sv ====
`include "knight_defines.svh"

package knight_pkg;

  // One-hot knight move. Bit 0 is (+1,+2) and the bits run counterclockwise.
  typedef logic [7:0] move_t;

  // A board square. The y field sits above x, matching the CTRL layout.
  typedef struct packed {
    logic [2:0] y;
    logic [2:0] x;
  } pos_t;

  // One replayed step: the move taken and the square it lands on.
  typedef struct packed {
    move_t move;
    pos_t  dest;
  } trace_entry_t;

  // Wishbone classic request, driven by the host.
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`KT_ADR_W-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  // Wishbone classic response, driven by the slave.
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  //////////////////////////////////////////////////
  // Move offsets as 3-bit two's complement values.
  //////////////////////////////////////////////////
  // Adding them to a 3-bit coordinate wraps correctly for any on-board result.
  function automatic logic [2:0] move_dx(move_t m);
    case (m)
      8'h01, 8'h20: return 3'b001;   // +1
      8'h02, 8'h10: return 3'b111;   // -1
      8'h04, 8'h08: return 3'b110;   // -2
      8'h40, 8'h80: return 3'b010;   // +2
      default:      return 3'b000;   // Not a legal move code.
    endcase
  endfunction

  function automatic logic [2:0] move_dy(move_t m);
    case (m)
      8'h01, 8'h02: return 3'b010;   // +2
      8'h04, 8'h80: return 3'b001;   // +1
      8'h08, 8'h40: return 3'b111;   // -1
      8'h10, 8'h20: return 3'b110;   // -2
      default:      return 3'b000;
    endcase
  endfunction

endpackage

// ==== rtl/knight_defines.svh ====
`ifndef KNIGHT_DEFINES_SVH
`define KNIGHT_DEFINES_SVH

// Board geometry. The solver's in-bounds tables assume a 5x5 board.
`define KT_DIM 5
`define KT_MOVES 24          // A full open tour takes 24 moves to visit 25 squares.

//////////////////////////////////////////////////
// Wishbone register map (word addresses).
//////////////////////////////////////////////////
`define KT_ADR_W 6           // Word address width of the slave port.
`define KT_REG_CTRL 0        // Start square and start request.
`define KT_REG_STAT 1        // Busy, ready and rejected flags.

// Trace entry i lives at this base plus i.
`define KT_TRACE_BASE 32

`endif
